/* common/sfu_settings.svh */
/*
 * SFU build settings
 * Lane, warp, data and tag widths shared by the package and the RTL
 */

`ifndef SFU_SETTINGS_SVH
`define SFU_SETTINGS_SVH

// Threads per warp, one SIMD lane each
`define SFU_NUM_LANES 4

// Warps in the core
`define SFU_NUM_WARPS 4

// Register and CSR width
`define SFU_XLEN 32

// Instruction tag width
`define SFU_UUID_BITS 8

`endif

/* common/sfu_pkg.sv */
/*
 * SFU types
 * Opcodes, CSR addresses, request and response records and the
 * warp control command, plus the leader lane helper
 */

`include "sfu_settings.svh"

package sfu_pkg;

    typedef enum logic [2:0] {
        TMC    = 3'd0,
        WSPAWN = 3'd1,
        CSRRW  = 3'd2,
        CSRRS  = 3'd3,
        CSRRC  = 3'd4
    } sfu_op_e;

    typedef enum logic [11:0] {
        SCRATCH0  = 12'h340,
        SCRATCH1  = 12'h341,
        SCRATCH2  = 12'h342,
        SCRATCH3  = 12'h343,
        THREAD_ID = 12'hCC0,
        WARP_ID   = 12'hCC1
    } csr_addr_e;

    typedef logic [$clog2(`SFU_NUM_LANES)-1:0] lane_idx_t;
    typedef logic [$clog2(`SFU_NUM_WARPS)-1:0] wid_t;
    typedef logic [`SFU_NUM_LANES-1:0][`SFU_XLEN-1:0] lane_data_t;

    typedef struct packed {
        logic [`SFU_UUID_BITS-1:0] uuid;
        wid_t                      wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        sfu_op_e                   op;
        logic [4:0]                rd;
        logic                      wb;
        csr_addr_e                 csr_addr;
        lane_data_t                rs1_data;
        lane_data_t                rs2_data;
    } sfu_req_t;

    typedef struct packed {
        logic [`SFU_UUID_BITS-1:0] uuid;
        wid_t                      wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [4:0]                rd;
        logic                      wb;
        lane_data_t                data;
    } sfu_rsp_t;

    typedef struct packed {
        wid_t                      wid;
        logic                      tmc_en;
        logic [`SFU_NUM_LANES-1:0] tmc_mask;
        logic                      wspawn_en;
        logic [`SFU_NUM_WARPS-1:0] wspawn_mask;
        logic [`SFU_XLEN-1:0]      wspawn_pc;
    } warp_ctl_t;

    // The leader lane is the lowest set bit of tmask
    function automatic lane_idx_t leader_lane(input logic [`SFU_NUM_LANES-1:0] tmask);
        lane_idx_t lane;
        lane = '0;
        for (int i = `SFU_NUM_LANES - 1; i >= 0; i--) begin
            if (tmask[i]) begin
                lane = lane_idx_t'(i);
            end
        end
        return lane;
    endfunction

endpackage

/* sfu/sfu_dispatch.sv */
/*
 * SFU dispatch stage
 * Holds one request, decodes its opcode and offers it to exactly one
 * execution block; only that block's ready can stall the stage
 */

`timescale 1ns/1ps

module sfu_dispatch (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  sfu_pkg::sfu_req_t req,
    output logic              req_ready,
    output logic              wctl_valid,
    output logic              csr_valid,
    output sfu_pkg::sfu_req_t req_q,
    input  logic              wctl_ready,
    input  logic              csr_ready
);

    logic valid_q;
    logic sel_wctl_q;
    logic ready_en_q;
    logic in_is_wctl;
    logic drain;
    logic fire_in;

    assign in_is_wctl = (req.op == sfu_pkg::TMC) || (req.op == sfu_pkg::WSPAWN);

    // Entry leaves when the block it is steered to takes it
    assign drain = valid_q && (sel_wctl_q ? wctl_ready : csr_ready);

    assign req_ready = ready_en_q && (!valid_q || drain);
    assign fire_in   = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            ready_en_q <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            if (fire_in) begin
                valid_q <= 1'b1;
            end else if (drain) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Decode once on entry
    always_ff @(posedge clk) begin
        if (fire_in) begin
            req_q      <= req;
            sel_wctl_q <= in_is_wctl;
        end
    end

    assign wctl_valid = valid_q && sel_wctl_q;
    assign csr_valid  = valid_q && !sel_wctl_q;

    // Only the block named by the held opcode sees the entry
    a_one_target: assert property (
        @(posedge clk) disable iff (reset)
        !(wctl_valid && csr_valid)
        && (wctl_valid == (valid_q && (req_q.op inside {sfu_pkg::TMC, sfu_pkg::WSPAWN})))
    );

endmodule

/* sfu/wctl_unit.sv */
/*
 * Warp control execution
 * Runs TMC and WSPAWN from the leader lane's operands, pulses a
 * scheduler command and returns a commit with no writeback
 */

`timescale 1ns/1ps
`include "sfu_settings.svh"

module wctl_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  sfu_pkg::sfu_req_t  req,
    output logic               ready,
    output logic               rsp_valid,
    output sfu_pkg::sfu_rsp_t  rsp,
    input  logic               rsp_ready,
    output logic               warp_ctl_valid,
    output sfu_pkg::warp_ctl_t warp_ctl
);

    logic                 fire;
    logic                 is_tmc;
    logic                 is_wspawn;
    sfu_pkg::lane_idx_t   lead;
    logic [`SFU_XLEN-1:0] rs1_lead;
    logic [`SFU_XLEN-1:0] rs2_lead;

    assign ready = !rsp_valid || rsp_ready;
    assign fire  = valid && ready;

    assign is_tmc    = (req.op == sfu_pkg::TMC);
    assign is_wspawn = (req.op == sfu_pkg::WSPAWN);

    assign lead     = sfu_pkg::leader_lane(req.tmask);
    assign rs1_lead = req.rs1_data[lead];
    assign rs2_lead = req.rs2_data[lead];

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid      <= 1'b0;
            warp_ctl_valid <= 1'b0;
        end else begin
            // Scheduler command lives for one cycle only
            warp_ctl_valid <= fire;
            if (fire) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rsp.uuid  <= req.uuid;
            rsp.wid   <= req.wid;
            rsp.tmask <= req.tmask;
            rsp.rd    <= req.rd;
            rsp.wb    <= 1'b0;
            rsp.data  <= '0;

            warp_ctl.wid         <= req.wid;
            warp_ctl.tmc_en      <= is_tmc;
            warp_ctl.tmc_mask    <= is_tmc ? rs1_lead[`SFU_NUM_LANES-1:0] : '0;
            warp_ctl.wspawn_en   <= is_wspawn;
            warp_ctl.wspawn_mask <= is_wspawn ? rs1_lead[`SFU_NUM_WARPS-1:0] : '0;
            warp_ctl.wspawn_pc   <= is_wspawn ? rs2_lead : '0;
        end
    end

endmodule

/* sfu/csr_unit.sv */
/*
 * CSR execution
 * Read-modify-write on four scratch CSRs, read-only thread and warp
 * identity CSRs; the old value returns in every lane
 */

`timescale 1ns/1ps
`include "sfu_settings.svh"

module csr_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  sfu_pkg::sfu_req_t req,
    output logic              ready,
    output logic              rsp_valid,
    output sfu_pkg::sfu_rsp_t rsp,
    input  logic              rsp_ready
);

    logic [`SFU_XLEN-1:0] scratch_q [4];
    logic                 fire;
    logic                 is_scratch;
    logic [1:0]           scratch_idx;
    logic [`SFU_XLEN-1:0] operand;
    logic [`SFU_XLEN-1:0] scratch_old;
    logic [`SFU_XLEN-1:0] scratch_new;
    sfu_pkg::lane_data_t  old_data;

    assign ready = !rsp_valid || rsp_ready;
    assign fire  = valid && ready;

    assign is_scratch  = req.csr_addr inside {sfu_pkg::SCRATCH0, sfu_pkg::SCRATCH1,
                                              sfu_pkg::SCRATCH2, sfu_pkg::SCRATCH3};
    assign scratch_idx = req.csr_addr[1:0];
    assign scratch_old = scratch_q[scratch_idx];
    assign operand     = req.rs1_data[sfu_pkg::leader_lane(req.tmask)];

    // Old value seen by each lane
    always_comb begin
        for (int i = 0; i < `SFU_NUM_LANES; i++) begin
            case (req.csr_addr)
                sfu_pkg::THREAD_ID: old_data[i] = `SFU_XLEN'(i);
                sfu_pkg::WARP_ID:   old_data[i] = `SFU_XLEN'(req.wid);
                default:            old_data[i] = is_scratch ? scratch_old : '0;
            endcase
        end
    end

    always_comb begin
        case (req.op)
            sfu_pkg::CSRRW: scratch_new = operand;
            sfu_pkg::CSRRS: scratch_new = scratch_old | operand;
            sfu_pkg::CSRRC: scratch_new = scratch_old & ~operand;
            default:        scratch_new = scratch_old;
        endcase
    end

    // Identity and unknown addresses ignore writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (fire && is_scratch) begin
            scratch_q[scratch_idx] <= scratch_new;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rsp.uuid  <= req.uuid;
            rsp.wid   <= req.wid;
            rsp.tmask <= req.tmask;
            rsp.rd    <= req.rd;
            rsp.wb    <= req.wb;
            rsp.data  <= old_data;
        end
    end

    a_no_wctl_op: assert property (
        @(posedge clk) disable iff (reset)
        fire |-> !(req.op inside {sfu_pkg::TMC, sfu_pkg::WSPAWN})
    );

endmodule

/* sfu/sfu_rsp_arb.sv */
/*
 * Response arbiter
 * Round-robin choice between two response streams into one
 * registered output stage
 */

`timescale 1ns/1ps

module sfu_rsp_arb (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [1:0]              valid_in,
    output logic [1:0]              ready_in,
    input  sfu_pkg::sfu_rsp_t [1:0] data_in,
    output logic                    valid_out,
    input  logic                    ready_out,
    output sfu_pkg::sfu_rsp_t       data_out
);

    logic last_q;
    logic sel;
    logic any_valid;
    logic out_ready;
    logic take;

    // Input 1 wins unless it was granted last and input 0 waits
    assign sel       = valid_in[1] && (!valid_in[0] || !last_q);
    assign any_valid = |valid_in;
    assign out_ready = !valid_out || ready_out;
    assign take      = any_valid && out_ready;

    assign ready_in[0] = out_ready && !sel;
    assign ready_in[1] = out_ready && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            last_q    <= 1'b0;
        end else if (take) begin
            valid_out <= 1'b1;
            last_q    <= sel;
        end else if (ready_out) begin
            valid_out <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_out <= data_in[sel];
        end
    end

    a_hold_out: assert property (
        @(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(data_out)
    );

endmodule

/* sfu/sfu_unit.sv */
/*
 * Special function unit top
 * Steers issued instructions to warp control or CSR execution and
 * merges both response streams into one commit stream
 */

`timescale 1ns/1ps

module sfu_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  sfu_pkg::sfu_req_t     req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output sfu_pkg::sfu_rsp_t     rsp,
    input  logic                  rsp_ready,
    output logic                  warp_ctl_valid,
    output sfu_pkg::warp_ctl_t    warp_ctl
);

    logic                          wctl_valid;
    logic                          wctl_ready;
    logic                          csr_valid;
    logic                          csr_ready;
    sfu_pkg::sfu_req_t             req_q;

    // Index 0 is warp control, index 1 is CSR
    logic [1:0]                    arb_valid;
    logic [1:0]                    arb_ready;
    sfu_pkg::sfu_rsp_t [1:0]       arb_data;

    sfu_dispatch dispatch_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .wctl_valid (wctl_valid),
        .csr_valid  (csr_valid),
        .req_q      (req_q),
        .wctl_ready (wctl_ready),
        .csr_ready  (csr_ready)
    );

    wctl_unit wctl_i (
        .clk            (clk),
        .reset          (reset),
        .valid          (wctl_valid),
        .req            (req_q),
        .ready          (wctl_ready),
        .rsp_valid      (arb_valid[0]),
        .rsp            (arb_data[0]),
        .rsp_ready      (arb_ready[0]),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

    csr_unit csr_i (
        .clk       (clk),
        .reset     (reset),
        .valid     (csr_valid),
        .req       (req_q),
        .ready     (csr_ready),
        .rsp_valid (arb_valid[1]),
        .rsp       (arb_data[1]),
        .rsp_ready (arb_ready[1])
    );

    sfu_rsp_arb rsp_arb_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (arb_valid),
        .ready_in  (arb_ready),
        .data_in   (arb_data),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready),
        .data_out  (rsp)
    );

endmodule

/* test/sfu_checker.sv */
/*
 * SFU response checker
 * Matches commit responses by uuid and warp control commands in order
 * against the expectations of the testbench model
 */

`timescale 1ns/1ps
`include "sfu_settings.svh"

module sfu_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               rsp_valid,
    input  logic               rsp_ready,
    input  sfu_pkg::sfu_rsp_t  rsp,
    input  logic               warp_ctl_valid,
    input  sfu_pkg::warp_ctl_t warp_ctl,
    input  logic               exp_push,
    input  logic               exp_is_wctl,
    input  sfu_pkg::sfu_rsp_t  exp_rsp,
    input  logic               exp_ctl_push,
    input  sfu_pkg::warp_ctl_t exp_ctl,
    input  logic               final_check,
    output int                 pending,
    output int                 checked,
    output int                 errors
);

    localparam int CW = $bits(sfu_pkg::lane_data_t);
    localparam int NUM_TAGS = 1 << `SFU_UUID_BITS;

    sfu_pkg::sfu_rsp_t        exp_mem [NUM_TAGS];
    logic                     exp_blk [NUM_TAGS];
    logic                     live [NUM_TAGS];
    // Outstanding uuids in request order, block flag on top
    logic [`SFU_UUID_BITS:0]  order_q [$];
    sfu_pkg::warp_ctl_t       ctl_q [$];

    task automatic compare(input string name, input logic [CW-1:0] got,
                           input logic [CW-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_rsp();
        sfu_pkg::sfu_rsp_t e;
        int idx;
        int first;
        logic blk;
        if (!live[rsp.uuid]) begin
            $display("unexpected response with uuid %h", rsp.uuid);
            errors++;
            return;
        end
        e = exp_mem[rsp.uuid];
        blk = exp_blk[rsp.uuid];
        idx = -1;
        first = -1;
        for (int i = 0; i < order_q.size(); i++) begin
            if (order_q[i][`SFU_UUID_BITS] == blk && first < 0) begin
                first = i;
            end
            if (order_q[i][`SFU_UUID_BITS-1:0] == rsp.uuid) begin
                idx = i;
            end
        end
        if (idx != first) begin
            $display("response uuid %h overtook an older one of its block", rsp.uuid);
            errors++;
        end
        if (idx >= 0) begin
            order_q.delete(idx);
        end
        compare("rsp.wid", CW'(rsp.wid), CW'(e.wid));
        compare("rsp.tmask", CW'(rsp.tmask), CW'(e.tmask));
        compare("rsp.rd", CW'(rsp.rd), CW'(e.rd));
        compare("rsp.wb", CW'(rsp.wb), CW'(e.wb));
        compare("rsp.data", rsp.data, e.data);
        live[rsp.uuid] = 1'b0;
        pending--;
        checked++;
    endtask

    task automatic check_ctl();
        sfu_pkg::warp_ctl_t c;
        if (ctl_q.size() == 0) begin
            $display("unexpected warp control command for warp %h", warp_ctl.wid);
            errors++;
            return;
        end
        c = ctl_q.pop_front();
        compare("warp_ctl.wid", CW'(warp_ctl.wid), CW'(c.wid));
        compare("warp_ctl.tmc_en", CW'(warp_ctl.tmc_en), CW'(c.tmc_en));
        compare("warp_ctl.tmc_mask", CW'(warp_ctl.tmc_mask), CW'(c.tmc_mask));
        compare("warp_ctl.wspawn_en", CW'(warp_ctl.wspawn_en), CW'(c.wspawn_en));
        compare("warp_ctl.wspawn_mask", CW'(warp_ctl.wspawn_mask), CW'(c.wspawn_mask));
        compare("warp_ctl.wspawn_pc", CW'(warp_ctl.wspawn_pc), CW'(c.wspawn_pc));
    endtask

    // Everything is sampled mid-cycle, away from the DUT's edges
    always @(negedge clk) begin
        if (reset) begin
            pending = 0;
            checked = 0;
            errors = 0;
            order_q.delete();
            ctl_q.delete();
            for (int i = 0; i < NUM_TAGS; i++) begin
                live[i] = 1'b0;
            end
        end else begin
            if (exp_push) begin
                exp_mem[exp_rsp.uuid] = exp_rsp;
                exp_blk[exp_rsp.uuid] = exp_is_wctl;
                live[exp_rsp.uuid] = 1'b1;
                order_q.push_back({exp_is_wctl, exp_rsp.uuid});
                pending++;
            end
            if (exp_ctl_push) begin
                ctl_q.push_back(exp_ctl);
            end
            if (rsp_valid && rsp_ready) begin
                check_rsp();
            end
            if (warp_ctl_valid) begin
                check_ctl();
            end
            if (final_check) begin
                for (int i = 0; i < NUM_TAGS; i++) begin
                    if (live[i]) begin
                        $display("response for uuid %h never arrived", i[`SFU_UUID_BITS-1:0]);
                        errors++;
                    end
                end
                if (ctl_q.size() != 0) begin
                    $display("%0d warp control commands never arrived", ctl_q.size());
                    errors++;
                end
            end
        end
    end

endmodule

/* test/sfu_tb.sv */
/*
 * SFU testbench
 * LFSR driven instruction stream, a reference model of the warp
 * control and CSR rules, and the response checker
 */

`timescale 1ns/1ps
`include "sfu_settings.svh"

module sfu_tb;

    localparam int WAIT_LIMIT = 200;
    localparam logic [11:0] UNKNOWN_CSR = 12'h7C0;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req_valid;
    sfu_pkg::sfu_req_t    req;
    logic                 req_ready;
    logic                 rsp_valid;
    sfu_pkg::sfu_rsp_t    rsp;
    logic                 rsp_ready;
    logic                 warp_ctl_valid;
    sfu_pkg::warp_ctl_t   warp_ctl;

    logic                 exp_push;
    logic                 exp_is_wctl;
    sfu_pkg::sfu_rsp_t    exp_rsp;
    logic                 exp_ctl_push;
    sfu_pkg::warp_ctl_t   exp_ctl;
    logic                 final_check;
    int                   pending;
    int                   checked;
    int                   chk_errors;

    logic [31:0]          lfsr = 32'haa004e56;
    logic [`SFU_XLEN-1:0] scratch_model [4];
    logic [7:0]           next_uuid;
    logic                 random_ready;
    logic                 timed_out;
    int                   tb_errors;
    int                   prev_errors;

    always #4 clk = ~clk;

    sfu_unit dut_i (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

    sfu_checker chk_i (
        .clk            (clk),
        .reset          (reset),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl),
        .exp_push       (exp_push),
        .exp_is_wctl    (exp_is_wctl),
        .exp_rsp        (exp_rsp),
        .exp_ctl_push   (exp_ctl_push),
        .exp_ctl        (exp_ctl),
        .final_check    (final_check),
        .pending        (pending),
        .checked        (checked),
        .errors         (chk_errors)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int lead_of(input logic [`SFU_NUM_LANES-1:0] m);
        for (int i = 0; i < `SFU_NUM_LANES; i++) begin
            if (m[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // Kind 0 scratch CSR, 1 any CSR address, 2 warp control, 3 mixed
    function automatic sfu_pkg::sfu_req_t make_req(input int kind);
        sfu_pkg::sfu_req_t r;
        logic [2:0] sel;
        logic [2:0] asel;
        r.uuid = next_uuid;
        next_uuid = next_uuid + 8'd1;
        r.wid = sfu_pkg::wid_t'(rand_bits(2));
        r.tmask = '0;
        while (r.tmask == '0) begin
            r.tmask = `SFU_NUM_LANES'(rand_bits(`SFU_NUM_LANES));
        end
        sel = 3'(rand_bits(3));
        if (kind == 2 || (kind == 3 && sel[2:1] == 2'b00)) begin
            r.op = sel[0] ? sfu_pkg::WSPAWN : sfu_pkg::TMC;
        end else begin
            case (sel[1:0])
                2'd0: r.op = sfu_pkg::CSRRW;
                2'd2: r.op = sfu_pkg::CSRRC;
                default: r.op = sfu_pkg::CSRRS;
            endcase
        end
        r.rd = 5'(rand_bits(5));
        r.wb = 1'(rand_bits(1));
        asel = 3'(rand_bits(3));
        if (kind == 0 || !asel[2]) begin
            r.csr_addr = sfu_pkg::csr_addr_e'(12'h340 + {10'd0, asel[1:0]});
        end else begin
            case (asel[1:0])
                2'd0: r.csr_addr = sfu_pkg::THREAD_ID;
                2'd1: r.csr_addr = sfu_pkg::WARP_ID;
                default: r.csr_addr = sfu_pkg::csr_addr_e'(UNKNOWN_CSR);
            endcase
        end
        for (int i = 0; i < `SFU_NUM_LANES; i++) begin
            r.rs1_data[i] = rand_bits(32);
            r.rs2_data[i] = rand_bits(32);
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        exp_push = 1'b0;
        exp_ctl_push = 1'b0;
        rsp_ready = random_ready ? (rand_bits(2) != 32'd0) : 1'b1;
    endtask

    // Applies one accepted request to the model and hands the result on
    task automatic model_accept(input sfu_pkg::sfu_req_t r);
        sfu_pkg::sfu_rsp_t e;
        int lead;
        int idx;
        logic [`SFU_XLEN-1:0] opnd;
        logic [`SFU_XLEN-1:0] old;
        logic is_wctl;
        logic is_tmc;
        lead = lead_of(r.tmask);
        opnd = r.rs1_data[lead];
        is_tmc = (r.op == sfu_pkg::TMC);
        is_wctl = is_tmc || (r.op == sfu_pkg::WSPAWN);
        e.uuid = r.uuid;
        e.wid = r.wid;
        e.tmask = r.tmask;
        e.rd = r.rd;
        e.wb = is_wctl ? 1'b0 : r.wb;
        e.data = '0;
        if (is_wctl) begin
            exp_ctl.wid = r.wid;
            exp_ctl.tmc_en = is_tmc;
            exp_ctl.tmc_mask = is_tmc ? opnd[`SFU_NUM_LANES-1:0] : '0;
            exp_ctl.wspawn_en = !is_tmc;
            exp_ctl.wspawn_mask = is_tmc ? '0 : opnd[`SFU_NUM_WARPS-1:0];
            exp_ctl.wspawn_pc = is_tmc ? '0 : r.rs2_data[lead];
            exp_ctl_push = 1'b1;
        end else if (r.csr_addr >= 12'h340 && r.csr_addr <= 12'h343) begin
            idx = int'(r.csr_addr - 12'h340);
            old = scratch_model[idx];
            for (int i = 0; i < `SFU_NUM_LANES; i++) begin
                e.data[i] = old;
            end
            case (r.op)
                sfu_pkg::CSRRW: scratch_model[idx] = opnd;
                sfu_pkg::CSRRS: scratch_model[idx] = old | opnd;
                default: scratch_model[idx] = old & ~opnd;
            endcase
        end else begin
            for (int i = 0; i < `SFU_NUM_LANES; i++) begin
                if (r.csr_addr == sfu_pkg::THREAD_ID) begin
                    e.data[i] = `SFU_XLEN'(i);
                end else if (r.csr_addr == sfu_pkg::WARP_ID) begin
                    e.data[i] = `SFU_XLEN'(r.wid);
                end
            end
        end
        exp_rsp = e;
        exp_is_wctl = is_wctl;
        exp_push = 1'b1;
    endtask

    task automatic send(input sfu_pkg::sfu_req_t r);
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        req = r;
        req_valid = !timed_out;
        while (!taken && !timed_out) begin
            @(negedge clk);
            taken = req_ready;
            next_cycle();
            waited++;
            if (taken) begin
                model_accept(r);
            end else if (waited > WAIT_LIMIT) begin
                $display("request uuid %h was never accepted", r.uuid);
                timed_out = 1'b1;
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic idle(input logic [31:0] n);
        repeat (n) next_cycle();
    endtask

    task automatic expect_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("CHECK FAILED %s got %h expected 0", name, v);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        int errs;
        waited = 0;
        next_cycle();
        while (pending != 0 && waited < WAIT_LIMIT && !timed_out) begin
            next_cycle();
            waited++;
        end
        if (pending != 0 && !timed_out) begin
            $display("%0d responses still outstanding after test %s", pending, name);
            timed_out = 1'b1;
        end
        errs = tb_errors + chk_errors;
        if (errs == prev_errors && !timed_out) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs - prev_errors);
        end
        prev_errors = errs;
    endtask

    initial begin
        sfu_pkg::sfu_req_t r;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        exp_push = 1'b0;
        exp_is_wctl = 1'b0;
        exp_rsp = '0;
        exp_ctl_push = 1'b0;
        exp_ctl = '0;
        final_check = 1'b0;
        random_ready = 1'b0;
        timed_out = 1'b0;
        tb_errors = 0;
        prev_errors = 0;
        next_uuid = '0;
        for (int i = 0; i < 4; i++) begin
            scratch_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        // Outputs idle and ready still low before the first free edge
        @(negedge clk);
        expect_low("req_ready", req_ready);
        expect_low("rsp_valid", rsp_valid);
        expect_low("warp_ctl_valid", warp_ctl_valid);
        next_cycle();
        r = make_req(0);
        r.op = sfu_pkg::CSRRS;
        r.rs1_data = '0;
        send(r);
        finish_test("reset_state");

        repeat (40) send(make_req(0));
        finish_test("scratch_rmw");
        repeat (40) send(make_req(1));
        finish_test("identity_csr");
        repeat (30) send(make_req(2));
        finish_test("warp_ctl");

        random_ready = 1'b1;
        repeat (300) begin
            send(make_req(3));
            if (rand_bits(2) == 32'd0) begin
                idle(rand_bits(2));
            end
        end
        random_ready = 1'b0;
        finish_test("mixed_traffic");

        final_check = 1'b1;
        next_cycle();
        final_check = 1'b0;
        $display("%0d responses checked, %0d errors", checked, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/sfu_pkg.sv
sfu/sfu_dispatch.sv
sfu/wctl_unit.sv
sfu/csr_unit.sv
sfu/sfu_rsp_arb.sv
sfu/sfu_unit.sv
test/sfu_checker.sv
test/sfu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module sfu_tb -o sfu_sim

out=$(./obj_dir/sfu_sim) || true
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
